/* echoPortal_defs.svh */
`ifndef ECHO_PORTAL_DEFS_SVH
`define ECHO_PORTAL_DEFS_SVH

// host beat width
`define BUS_WIDTH 32

// payload limits in words
`define MAX_REQ_WORDS 4  // extra request words are dropped
`define MAX_IND_WORDS 5  // room for the appended sum word

// portal numbers
`define ECHO_REQUEST_ID    16'h0005
`define ECHO_INDICATION_ID 16'h0006

// method codes carried in the header
`define METHOD_ECHO  8'h00
`define METHOD_SWAP  8'h01
`define METHOD_SUM   8'h02
`define METHOD_ERROR 8'hFF  // reply code for an unknown method

`endif

/* echoPortalPkg.sv */
`include "echoPortal_defs.svh"

package echoPortalPkg;

  // header word as it travels on the bus
  typedef struct packed {
    logic [7:0]  wordCount;  // ignored on requests
    logic [7:0]  method;
    logic [15:0] portal;
  } portalHeaderT;

  // assembled request, one queue item
  typedef struct packed {
    logic [7:0]                                 method;
    logic [2:0]                                 wordCount;  // 0 to 4
    logic [`MAX_REQ_WORDS-1:0][`BUS_WIDTH-1:0] words;
  } requestMsgT;

  // reply built by the execute step
  typedef struct packed {
    logic [7:0]                                 method;
    logic [2:0]                                 wordCount;  // 0 to 5
    logic [`MAX_IND_WORDS-1:0][`BUS_WIDTH-1:0] words;
  } indicationMsgT;

endpackage

/* requestDecode.sv */
`timescale 1ns/10ps
`include "echoPortal_defs.svh"

module requestDecode (
  input  logic                      CLK,
  input  logic                      RST_N,
  input  logic                      sinkBeat,
  input  logic [`BUS_WIDTH-1:0]     sinkData,
  input  logic                      sinkLast,
  output logic                      sinkReady,
  input  logic                      reqFull,
  output logic                      reqPush,
  output echoPortalPkg::requestMsgT reqData,
  output logic                      badPortal
);
  import echoPortalPkg::*;

  portalHeaderT hdrIn;
  logic         beatTaken;
  logic         keepWord;
  logic         expectHeader;  // next beat opens a message
  logic         msgDone;       // message complete and waiting to leave
  logic         portalOk;
  logic [7:0]   method;
  logic [2:0]   wordCount;
  logic [`MAX_REQ_WORDS-1:0][`BUS_WIDTH-1:0] words;

  assign hdrIn     = sinkData;
  assign sinkReady = !msgDone;  // held low while a message is parked
  assign beatTaken = sinkBeat && sinkReady;
  assign keepWord  = beatTaken && !expectHeader && (wordCount < `MAX_REQ_WORDS);

  // parked message either goes to the queue or is thrown away
  assign reqPush   = msgDone && portalOk && !reqFull;
  assign badPortal = msgDone && !portalOk;

  assign reqData.method    = method;
  assign reqData.wordCount = wordCount;
  assign reqData.words     = words;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      expectHeader <= 1'b1;
      msgDone      <= 1'b0;
      portalOk     <= 1'b0;
      method       <= '0;
      wordCount    <= '0;
    end else begin
      if (reqPush || badPortal)
        msgDone <= 1'b0;
      if (beatTaken) begin
        expectHeader <= sinkLast;
        if (sinkLast)
          msgDone <= 1'b1;
        if (expectHeader) begin
          // header beat latches routing info and restarts the count
          portalOk  <= (hdrIn.portal == `ECHO_REQUEST_ID);
          method    <= hdrIn.method;
          wordCount <= '0;
        end else if (keepWord) begin
          wordCount <= wordCount + 3'd1;
        end
      end
    end
  end

  // payload words land in arrival order and words past the limit are lost
  always_ff @(posedge CLK) begin
    if (keepWord)
      words[wordCount[1:0]] <= sinkData;
  end

  // the request queue only fills through a push from this side
  fullFollowsPush: assert property (
    @(posedge CLK) disable iff (!RST_N)
    $rose(reqFull) |-> $past(reqPush)
  );

endmodule

/* msgQueue.sv */
`timescale 1ns/10ps

module msgQueue #(
  parameter type payloadT = logic [31:0]
) (
  input  logic    CLK,
  input  logic    RST_N,
  input  logic    push,
  input  payloadT pushData,
  output logic    full,
  input  logic    pop,
  output payloadT head,
  output logic    empty
);

  payloadT    mem [2];
  logic       wrPtr;
  logic       rdPtr;
  logic [1:0] count;  // 0, 1 or 2 items

  assign full  = (count == 2'd2);
  assign empty = (count == 2'd0);
  assign head  = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (push)
      mem[wrPtr] <= pushData;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      count <= 2'd0;
    end else begin
      if (push)
        wrPtr <= !wrPtr;
      if (pop)
        rdPtr <= !rdPtr;
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  noPushWhenFull: assert property (
    @(posedge CLK) disable iff (!RST_N) push |-> !full
  );

  noPopWhenEmpty: assert property (
    @(posedge CLK) disable iff (!RST_N) pop |-> !empty
  );

endmodule

/* echoExecute.sv */
`timescale 1ns/10ps
`include "echoPortal_defs.svh"

module echoExecute (
  input  logic                         reqEmpty,
  input  echoPortalPkg::requestMsgT    reqHead,
  output logic                         reqPop,
  input  logic                         indFull,
  output logic                         indPush,
  output echoPortalPkg::indicationMsgT indData
);

  localparam int HALF = `BUS_WIDTH / 2;

  logic [`BUS_WIDTH-1:0] sum;

  // one request in, one indication out, same cycle
  assign reqPop  = !reqEmpty && !indFull;
  assign indPush = reqPop;

  // wraps modulo 2**32, empty payload gives 0
  always_comb begin
    sum = '0;
    for (int i = 0; i < `MAX_REQ_WORDS; i++) begin
      if (i < reqHead.wordCount)
        sum = sum + reqHead.words[i];
    end
  end

  always_comb begin
    indData           = '0;
    indData.method    = reqHead.method;
    indData.wordCount = reqHead.wordCount;
    for (int i = 0; i < `MAX_REQ_WORDS; i++) begin
      indData.words[i] = reqHead.words[i];
    end

    case (reqHead.method)
      `METHOD_ECHO: begin
        // payload already copied
      end
      `METHOD_SWAP: begin
        for (int i = 0; i < `MAX_REQ_WORDS; i++) begin
          indData.words[i] = {reqHead.words[i][HALF-1:0],
                              reqHead.words[i][`BUS_WIDTH-1:HALF]};
        end
      end
      `METHOD_SUM: begin
        // sum goes right after the last payload word
        indData.words[reqHead.wordCount] = sum;
        indData.wordCount                = reqHead.wordCount + 3'd1;
      end
      default: begin
        indData.method    = `METHOD_ERROR;
        indData.wordCount = '0;  // header-only reply
      end
    endcase
  end

endmodule

/* indicationSerializer.sv */
`timescale 1ns/10ps
`include "echoPortal_defs.svh"

module indicationSerializer (
  input  logic                         CLK,
  input  logic                         RST_N,
  input  logic                         indEmpty,
  input  echoPortalPkg::indicationMsgT indHead,
  output logic                         indPop,
  output logic                         sourceValid,
  output logic [`BUS_WIDTH-1:0]        sourceData,
  output logic                         sourceLast,
  input  logic                         sourceBeat
);
  import echoPortalPkg::*;

  portalHeaderT hdrOut;
  logic         beatDone;
  logic [2:0]   beatsLeft;  // header plus payload beats still to go
  logic [`MAX_IND_WORDS:0][`BUS_WIDTH-1:0] beatBuf;  // word 0 is on the bus

  assign indPop     = !sourceValid && !indEmpty;
  assign beatDone   = sourceBeat && sourceValid;
  assign sourceData = beatBuf[0];
  assign sourceLast = (beatsLeft == 3'd1);

  always_comb begin
    hdrOut.wordCount = 8'(indHead.wordCount);
    hdrOut.method    = indHead.method;
    hdrOut.portal    = `ECHO_INDICATION_ID;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      sourceValid <= 1'b0;
      beatsLeft   <= '0;
    end else if (indPop) begin
      sourceValid <= 1'b1;
      beatsLeft   <= indHead.wordCount + 3'd1;
    end else if (beatDone) begin
      beatsLeft <= beatsLeft - 3'd1;
      if (sourceLast)
        sourceValid <= 1'b0;  // idle again until the next load
    end
  end

  // header first and then payload from the lowest word up
  always_ff @(posedge CLK) begin
    if (indPop)
      beatBuf <= {indHead.words, hdrOut};
    else if (beatDone)
      beatBuf <= beatBuf >> `BUS_WIDTH;
  end

  // host only strobes while a beat is offered
  beatNeedsValid: assert property (
    @(posedge CLK) disable iff (!RST_N)
    sourceBeat |-> sourceValid
  );

endmodule

/* echoPortalTop.sv */
`timescale 1ns/10ps
`include "echoPortal_defs.svh"

module echoPortalTop (
  input  logic                  CLK,
  input  logic                  RST_N,
  input  logic                  sinkBeat,
  input  logic [`BUS_WIDTH-1:0] sinkData,
  input  logic                  sinkLast,
  output logic                  sinkReady,
  input  logic                  sourceBeat,
  output logic                  sourceValid,
  output logic [`BUS_WIDTH-1:0] sourceData,
  output logic                  sourceLast,
  output logic                  badPortal
);
  import echoPortalPkg::*;

  logic          reqPush, reqFull, reqPop, reqEmpty;
  logic          indPush, indFull, indPop, indEmpty;
  requestMsgT    reqData, reqHead;
  indicationMsgT indData, indHead;

  requestDecode requestDecode_i (
    .CLK(CLK), .RST_N(RST_N),
    .sinkBeat(sinkBeat), .sinkData(sinkData), .sinkLast(sinkLast), .sinkReady(sinkReady),
    .reqFull(reqFull), .reqPush(reqPush), .reqData(reqData), .badPortal(badPortal)
  );

  msgQueue #(.payloadT(requestMsgT)) reqQueue_i (
    .CLK(CLK), .RST_N(RST_N),
    .push(reqPush), .pushData(reqData), .full(reqFull),
    .pop(reqPop), .head(reqHead), .empty(reqEmpty)
  );

  echoExecute echoExecute_i (
    .reqEmpty(reqEmpty), .reqHead(reqHead), .reqPop(reqPop),
    .indFull(indFull), .indPush(indPush), .indData(indData)
  );

  msgQueue #(.payloadT(indicationMsgT)) indQueue_i (
    .CLK(CLK), .RST_N(RST_N),
    .push(indPush), .pushData(indData), .full(indFull),
    .pop(indPop), .head(indHead), .empty(indEmpty)
  );

  indicationSerializer indicationSerializer_i (
    .CLK(CLK), .RST_N(RST_N),
    .indEmpty(indEmpty), .indHead(indHead), .indPop(indPop),
    .sourceValid(sourceValid), .sourceData(sourceData), .sourceLast(sourceLast),
    .sourceBeat(sourceBeat)
  );

endmodule

/* echoPortal_tb.sv */
`timescale 1ns/10ps
`include "echoPortal_defs.svh"

module echoPortal_tb;

  localparam int NUM_MSGS       = 200;
  localparam int CYCLES_PER_MSG = 40;
  localparam int TIMEOUT_CYCLES = NUM_MSGS * CYCLES_PER_MSG;
  localparam logic [31:0] SEED  = 32'd93910;

  logic                  CLK = 1'b0;
  logic                  RST_N;
  logic                  sinkBeat;
  logic [`BUS_WIDTH-1:0] sinkData;
  logic                  sinkLast;
  logic                  sinkReady;
  logic                  sourceBeat;
  logic                  sourceValid;
  logic [`BUS_WIDTH-1:0] sourceData;
  logic                  sourceLast;
  logic                  badPortal;

  logic [32:0] expQ[$];  // {last, data} per reply beat
  logic [31:0] stimState  = SEED;
  logic [31:0] stallState = SEED ^ 32'h9e3779b9;  // own stream for the source side
  int          sentCount   = 0;
  int          expBadCount = 0;
  int          badCount    = 0;
  int          cycleCount  = 0;
  int          dataErrors  = 0;
  int          lastErrors  = 0;
  int          badErrors   = 0;
  int          otherErrors = 0;
  logic        readyLowLast = 1'b0;
  logic        readyHeldLow = 1'b0;  // sink stayed closed for 2+ cycles

  echoPortalTop echoPortalTop_i (
    .CLK(CLK), .RST_N(RST_N),
    .sinkBeat(sinkBeat), .sinkData(sinkData), .sinkLast(sinkLast), .sinkReady(sinkReady),
    .sourceBeat(sourceBeat), .sourceValid(sourceValid), .sourceData(sourceData),
    .sourceLast(sourceLast), .badPortal(badPortal)
  );

  always #5 CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] stimRand();
    stimState = xorshift32(stimState);
    return stimState;
  endfunction

  // expected reply beats for one request, straight from the method rules
  function automatic void expectReply(input logic [15:0] portal, input logic [7:0] method,
                                      input int len, input logic [5:0][31:0] words);
    logic [4:0][31:0] reply;
    logic [31:0]      sum;
    logic [7:0]       replyMethod;
    int               keep;
    int               count;
    reply = '0;
    sum   = '0;
    if (portal != `ECHO_REQUEST_ID) begin
      expBadCount++;  // dropped, only a badPortal pulse
      return;
    end
    keep        = (len > `MAX_REQ_WORDS) ? `MAX_REQ_WORDS : len;
    replyMethod = method;
    count       = keep;
    for (int i = 0; i < keep; i++) begin
      sum = sum + words[i];
      if (method == `METHOD_SWAP)
        reply[i] = {words[i][15:0], words[i][31:16]};
      else
        reply[i] = words[i];
    end
    if (method == `METHOD_SUM) begin
      reply[keep] = sum;
      count       = keep + 1;
    end else if (method != `METHOD_ECHO && method != `METHOD_SWAP) begin
      replyMethod = `METHOD_ERROR;
      count       = 0;
    end
    expQ.push_back({count == 0, 8'(count), replyMethod, `ECHO_INDICATION_ID});
    for (int i = 0; i < count; i++)
      expQ.push_back({i == count - 1, reply[i]});
  endfunction

  // one sink beat after an optional gap, held off while sinkReady is low
  task automatic sendBeat(input logic [31:0] data, input logic last);
    logic [31:0] r;
    int          gap;
    r   = stimRand();
    gap = (r[1:0] == 2'd0) ? int'(r[3:2]) + 1 : 0;
    repeat (gap) begin
      @(posedge CLK);
      #1;
      sinkBeat = 1'b0;
    end
    @(posedge CLK);
    #1;
    while (!sinkReady) begin
      sinkBeat = 1'b0;
      @(posedge CLK);
      #1;
    end
    sinkBeat = 1'b1;
    sinkData = data;
    sinkLast = last;
  endtask

  task automatic sendMessage();
    logic [31:0]      r;
    logic [15:0]      portal;
    logic [7:0]       method;
    int               len;
    logic [5:0][31:0] words;
    r      = stimRand();
    portal = `ECHO_REQUEST_ID;
    if (r[2:0] == 3'd0)
      portal = (r[23:8] == `ECHO_REQUEST_ID) ? 16'h0007 : r[23:8];  // about 1 in 8 misrouted
    method = 8'(r[25:24]);  // 3 is unknown
    len    = int'(r[31:26]) % 7;
    for (int i = 0; i < 6; i++)
      words[i] = stimRand();
    expectReply(portal, method, len, words);
    sendBeat({r[7:0], method, portal}, len == 0);  // junk count field, ignored by the DUT
    for (int i = 0; i < len; i++)
      sendBeat(words[i], i == len - 1);
    sentCount++;
  endtask

  task automatic reportAndStop();
    int total;
    if (expQ.size() != 0) begin
      $display("%0d expected reply beats never arrived", expQ.size());
      otherErrors++;
    end
    total = dataErrors + lastErrors + badErrors + otherErrors;
    $display("errors: sourceData %0d, sourceLast %0d, badPortal %0d, other %0d",
             dataErrors, lastErrors, badErrors, otherErrors);
    if (total == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  endtask

  // host source side, random stalls plus one long stall halfway through
  initial begin : sourceDriver
    int          stallLeft;
    int          snapSent;
    logic [31:0] r;
    logic        bigDone;
    stallLeft = 0;
    bigDone   = 1'b0;
    forever begin
      @(posedge CLK);
      snapSent = sentCount;
      #1;
      stallState = xorshift32(stallState);
      r          = stallState;
      if (!bigDone && snapSent == NUM_MSGS / 2) begin
        stallLeft = 60;  // long enough to back up both queues
        bigDone   = 1'b1;
      end else if (stallLeft == 0 && r[6:0] == 7'd0) begin
        stallLeft = 20 + int'(r[11:7]);
      end
      if (stallLeft > 0) begin
        stallLeft--;
        sourceBeat = 1'b0;
      end else begin
        sourceBeat = sourceValid && (r[13:12] != 2'd0);
      end
    end
  end

  always @(posedge CLK) begin : compareBeat
    logic [32:0] exp;
    if (RST_N && sourceValid && sourceBeat) begin
      assert (expQ.size() != 0) else begin
        $display("reply beat %h arrived with no reply expected", sourceData);
        otherErrors++;
      end
      if (expQ.size() != 0) begin
        exp = expQ.pop_front();
        assert (sourceData === exp[31:0]) else begin
          $display("[ERROR] sourceData expected %h actual %h", exp[31:0], sourceData);
          dataErrors++;
        end
        assert (sourceLast === exp[32]) else begin
          $display("[ERROR] sourceLast expected %h actual %h", exp[32], sourceLast);
          lastErrors++;
        end
      end
    end
  end

  always @(posedge CLK) begin
    if (RST_N) begin
      if (badPortal)
        badCount++;
      if (!sinkReady && readyLowLast)
        readyHeldLow = 1'b1;
      readyLowLast = !sinkReady;
    end
  end

  initial begin : watchdog
    while (cycleCount < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycleCount++;
    end
    $display("timeout after %0d cycles, replies stopped arriving", TIMEOUT_CYCLES);
    otherErrors++;
    reportAndStop();
  end

  initial begin
    RST_N      = 1'b0;
    sinkBeat   = 1'b0;
    sinkData   = '0;
    sinkLast   = 1'b0;
    sourceBeat = 1'b0;
    repeat (10) @(posedge CLK);
    #1;
    RST_N = 1'b1;

    for (int m = 0; m < NUM_MSGS; m++)
      sendMessage();
    @(posedge CLK);
    #1;
    sinkBeat = 1'b0;

    // drain replies, then leave room for a trailing badPortal pulse
    while (expQ.size() != 0 || sourceValid)
      @(posedge CLK);
    repeat (4) @(posedge CLK);

    assert (badCount == expBadCount) else begin
      $display("[ERROR] badPortal expected %h actual %h", expBadCount, badCount);
      badErrors++;
    end
    assert (readyHeldLow) else begin
      $display("sinkReady was never held low by a full request queue");
      otherErrors++;
    end
    reportAndStop();
  end

endmodule

/* echoPortal.f */
+incdir+.
echoPortalPkg.sv
requestDecode.sv
msgQueue.sv
echoExecute.sv
indicationSerializer.sv
echoPortalTop.sv
echoPortal_tb.sv
